// ==== common/core_pkg.sv ====
package core_pkg;

  import isa_pkg::*;

  localparam int data_w = 8;
  localparam int pair_w = 16;

  // flag byte bit positions.
  localparam int flag_s  = 7;
  localparam int flag_z  = 6;
  localparam int flag_p  = 2;
  localparam int flag_cy = 0;

  // held operation as seen by the alu.
  typedef struct packed {
    logic              valid;
    op_code_e          code;
    reg_addr_t         dst;
    logic [pair_w-1:0] imm;
  } alu_req_t;

  // write-back into the register file.
  typedef struct packed {
    logic              write_en;
    logic              rp_en;         // pair write when set.
    logic              flag_write_en; // only honored without write_en.
    reg_addr_t         addr;
    logic [pair_w-1:0] data;
    logic [data_w-1:0] flags;
  } wb_t;

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

  // byte register addresses in 8080 order.
  localparam logic [2:0] reg_b     = 3'd0;
  localparam logic [2:0] reg_c     = 3'd1;
  localparam logic [2:0] reg_d     = 3'd2;
  localparam logic [2:0] reg_e     = 3'd3;
  localparam logic [2:0] reg_h     = 3'd4;
  localparam logic [2:0] reg_l     = 3'd5;
  localparam logic [2:0] reg_flags = 3'd6;
  localparam logic [2:0] reg_a     = 3'd7;

  // pair address is the low two bits of a register address.
  localparam logic [1:0] pair_bc = 2'd0;
  localparam logic [1:0] pair_de = 2'd1;
  localparam logic [1:0] pair_hl = 2'd2;
  localparam logic [1:0] pair_af = 2'd3;

  typedef logic [2:0] reg_addr_t;

  typedef enum logic [3:0] {
    op_nop = 4'd0,
    op_mov = 4'd1,
    op_mvi = 4'd2,
    op_lxi = 4'd3,
    op_add = 4'd4,
    op_sub = 4'd5,
    op_ana = 4'd6,
    op_xra = 4'd7,
    op_ora = 4'd8,
    op_cmp = 4'd9,
    op_inr = 4'd10,
    op_dcr = 4'd11,
    op_inx = 4'd12,
    op_dcx = 4'd13
  } op_code_e;

  // operand word holds a source register or an immediate.
  typedef union packed {
    struct packed {
      logic [12:0] pad;
      reg_addr_t   src;
    } src_view;
    logic [15:0] imm_view; // low byte for mvi.
  } operand_u;

  typedef struct packed {
    op_code_e  code;
    reg_addr_t dst;
    operand_u  operand;
  } core_op_t;

endpackage

// ==== dv/reg_core_chk.sv ====
`timescale 1ns/1ps

module reg_core_chk import core_pkg::*; (
  input logic              clk,
  input logic              n_rst,
  input wb_t               wb,
  input logic [data_w-1:0] flags,
  input logic [data_w-1:0] regs [8]
);

  logic [8*data_w-1:0] all_regs;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      all_regs[i*data_w +: data_w] = regs[i];
    end
  end

  wb_exclusive: assert property (@(posedge clk) disable iff (!n_rst)
    !(wb.write_en && wb.flag_write_en))
    else $error("byte or pair write and flag write in the same cycle");

  reset_clears: assert property (@(posedge clk) !n_rst |=> all_regs == '0)
    else $error("registers not zero after reset");

  // pair 3 carries the flags in its low byte.
  af_write_flags: assert property (@(posedge clk) disable iff (!n_rst)
    wb.write_en && wb.rp_en && wb.addr[1:0] == 2'd3 |=> flags == $past(wb.data[data_w-1:0]))
    else $error("pair 3 write did not update the flags");

endmodule

bind reg_file reg_core_chk chk_i (.clk(clk), .n_rst(n_rst), .wb(wb), .flags(flags), .regs(regs));

// ==== dv/reg_core_tb.sv ====
`timescale 1ns/1ps

module reg_core_tb import isa_pkg::*, core_pkg::*;;

  typedef struct packed {
    core_op_t          op;
    logic              insp_rp;
    reg_addr_t         insp_addr;
    logic [data_w-1:0] exp_acc;
    logic [data_w-1:0] exp_flags;
    logic [pair_w-1:0] exp_insp;
  } step_t;

  logic              clk = 1'b0;
  logic              n_rst = 1'b0;
  logic              op_valid;
  core_op_t          op;
  logic              insp_rp;
  reg_addr_t         insp_addr;
  logic [pair_w-1:0] insp_data;
  logic [data_w-1:0] accumulator;
  logic [data_w-1:0] flags;

  logic [data_w-1:0] m [8];     // reference register model.
  step_t             steps [$];
  logic [pair_w-1:0] exp_q [$]; // {a, flags} in issue order.
  int                errors = 0;

  reg_core dut_i (.*);

  always #5 clk = ~clk;

  initial begin
    repeat (3) @(posedge clk);
    #1 n_rst = 1'b1;
  end

  function automatic reg_addr_t hi_reg(input logic [1:0] p);
    return (p == 2'd3) ? 3'd7 : {p, 1'b0};
  endfunction

  function automatic reg_addr_t lo_reg(input logic [1:0] p);
    return (p == 2'd3) ? 3'd6 : {p, 1'b1};
  endfunction

  function automatic logic [pair_w-1:0] model_read(input logic rp, input reg_addr_t addr);
    return rp ? {m[hi_reg(addr[1:0])], m[lo_reg(addr[1:0])]} : {8'h00, m[addr]};
  endfunction

  function automatic logic [data_w-1:0] flags_of(input logic [data_w-1:0] r, input logic cy);
    logic even;
    even = 1'b1;
    for (int i = 0; i < data_w; i++) even = even ^ r[i];
    return {r[7], r == 8'h00, 3'b000, even, 1'b0, cy};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic model_apply(input core_op_t o);
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] r;
    logic              cy;
    logic [pair_w-1:0] pv;
    a  = m[reg_a];
    b  = m[o.operand.src_view.src];
    pv = model_read(1'b1, o.dst);
    cy = 1'b0;
    r  = '0;
    case (o.code)
      op_add: {cy, r} = {1'b0, a} + {1'b0, b};
      op_sub, op_cmp: begin
        r  = a - b;
        cy = a < b; // borrow.
      end
      op_ana: r = a & b;
      op_xra: r = a ^ b;
      op_ora: r = a | b;
      op_mov: m[o.dst] = b;
      op_mvi: m[o.dst] = o.operand.imm_view[data_w-1:0];
      op_inr: m[o.dst] = m[o.dst] + 8'd1;
      op_dcr: m[o.dst] = m[o.dst] - 8'd1;
      op_lxi: pv = o.operand.imm_view;
      op_inx: pv = pv + 16'd1;
      op_dcx: pv = pv - 16'd1;
      default: ;
    endcase
    if (o.code inside {op_lxi, op_inx, op_dcx}) begin
      m[hi_reg(o.dst[1:0])] = pv[pair_w-1:data_w];
      m[lo_reg(o.dst[1:0])] = pv[data_w-1:0];
    end
    if (o.code inside {op_add, op_sub, op_ana, op_xra, op_ora}) m[reg_a] = r;
    if (o.code inside {op_add, op_sub, op_ana, op_xra, op_ora, op_cmp}) begin
      m[reg_flags] = flags_of(r, cy);
    end
  endtask

  task automatic add_step(input op_code_e code, input reg_addr_t dst,
                          input logic [pair_w-1:0] opnd, input logic rp, input reg_addr_t ia);
    step_t s;
    s.op.code             = code;
    s.op.dst              = dst;
    s.op.operand.imm_view = opnd;
    s.insp_rp             = rp;
    s.insp_addr           = ia;
    model_apply(s.op);
    s.exp_acc   = m[reg_a];
    s.exp_flags = m[reg_flags];
    s.exp_insp  = model_read(rp, ia);
    steps.push_back(s);
  endtask

  task automatic check_byte(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input logic [data_w-1:0] got, input logic [data_w-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: flags are %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_pair(input logic [pair_w-1:0] got, input logic [pair_w-1:0] exp,
                            input reg_addr_t addr);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: inspect %0d reads %h, expected %h", $time, addr, got, exp);
    end
  endtask

  // one op, then idle until its write-back is visible.
  task automatic apply_step(input step_t s);
    op_valid  = 1'b1;
    op        = s.op;
    insp_rp   = s.insp_rp;
    insp_addr = s.insp_addr;
    @(posedge clk);
    #1;
    op_valid = 1'b0;
    @(posedge clk);
    #1;
    check_byte(accumulator, s.exp_acc, "accumulator");
    check_flags(flags, s.exp_flags);
    check_pair(insp_data, s.exp_insp, s.insp_addr);
  endtask

  initial begin
    int                n;
    logic [31:0]       rnd;
    core_op_t          ro;
    logic [pair_w-1:0] e;
    op_valid  = 1'b0;
    op        = '0;
    insp_rp   = 1'b0;
    insp_addr = '0;
    rnd       = 32'd77645;
    n         = 0;
    ro        = '0;
    foreach (m[i]) m[i] = '0;
    for (int i = 0; i < 8; i++) add_step(op_nop, reg_b, 16'h0000, 1'b0, 3'(i));
    for (int i = 0; i < 4; i++) add_step(op_nop, reg_b, 16'h0000, 1'b1, 3'(i));
    add_step(op_mvi, reg_b, 16'hab12, 1'b0, reg_b); // high byte ignored.
    add_step(op_mvi, reg_c, 16'h0034, 1'b1, 3'(pair_bc));
    add_step(op_mov, reg_d, 16'(reg_b), 1'b0, reg_d);
    add_step(op_mov, reg_e, 16'(reg_c), 1'b1, 3'(pair_de));
    add_step(op_lxi, 3'(pair_de), 16'h5678, 1'b1, 3'(pair_de));
    add_step(op_lxi, 3'(pair_hl), 16'h00ff, 1'b1, 3'(pair_hl));
    add_step(op_inx, 3'(pair_hl), 16'h0000, 1'b1, 3'(pair_hl));
    add_step(op_lxi, 3'(pair_bc), 16'h0000, 1'b1, 3'(pair_bc));
    add_step(op_dcx, 3'(pair_bc), 16'h0000, 1'b1, 3'(pair_bc)); // wraps to ffff.
    add_step(op_lxi, 3'(pair_af), 16'h5a81, 1'b1, 3'(pair_af));
    add_step(op_mvi, reg_a, 16'h00f0, 1'b0, reg_a);
    add_step(op_mvi, reg_b, 16'h0020, 1'b0, reg_b);
    add_step(op_add, reg_a, 16'(reg_b), 1'b1, 3'(pair_af)); // carry out.
    add_step(op_sub, reg_a, 16'(reg_b), 1'b1, 3'(pair_af)); // borrow.
    add_step(op_ana, reg_a, 16'(reg_l), 1'b1, 3'(pair_af));
    add_step(op_add, reg_a, 16'(reg_e), 1'b1, 3'(pair_af));
    add_step(op_ora, reg_a, 16'(reg_d), 1'b1, 3'(pair_af));
    add_step(op_xra, reg_a, 16'(reg_a), 1'b1, 3'(pair_af));
    add_step(op_mvi, reg_a, 16'h0055, 1'b0, reg_a);
    add_step(op_mvi, reg_c, 16'h0055, 1'b0, reg_c);
    add_step(op_cmp, reg_a, 16'(reg_c), 1'b0, reg_a);
    add_step(op_cmp, reg_a, 16'(reg_d), 1'b0, reg_a); // borrow.
    add_step(op_mvi, reg_d, 16'h00ff, 1'b0, reg_d);
    add_step(op_inr, reg_d, 16'h0000, 1'b0, reg_d);
    add_step(op_dcr, reg_d, 16'h0000, 1'b1, 3'(pair_de));
    while (!n_rst && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!n_rst) begin
      errors++;
      $display("timeout: reset was never released");
    end else begin
      #1;
      foreach (steps[i]) apply_step(steps[i]);
      for (int i = 0; i < 42; i++) begin
        @(posedge clk);
        #1;
        if (i >= 2) begin
          e = exp_q.pop_front();
          check_byte(accumulator, e[pair_w-1:data_w], "random accumulator");
          check_flags(flags, e[data_w-1:0]);
        end
        op_valid = (i < 40);
        if (i < 40) begin
          rnd                  = xorshift(rnd);
          ro.code              = op_code_e'(4'd4 + 4'(rnd[7:0] % 8'd6));
          ro.dst               = reg_a;
          ro.operand.imm_view  = 16'(rnd[10:8]);
          model_apply(ro);
          exp_q.push_back({m[reg_a], m[reg_flags]});
          op = ro;
        end
      end
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
common/isa_pkg.sv
common/core_pkg.sv
regfile/reg_file.sv
hw/op_decoder.sv
hw/alu8.sv
hw/reg_core.sv
dv/reg_core_chk.sv
dv/reg_core_tb.sv

// ==== hw/alu8.sv ====
`timescale 1ns/1ps

module alu8 import isa_pkg::*, core_pkg::*; (
  input  alu_req_t          req,
  input  logic [pair_w-1:0] read_data_1,
  input  logic [data_w-1:0] accumulator,
  input  logic [data_w-1:0] flags,
  output wb_t               wb
);

  logic [data_w-1:0] op_b;
  logic [data_w:0]   arith;     // top bit is carry or borrow.
  logic [data_w-1:0] new_flags;

  function automatic logic [data_w-1:0] calc_flags(input logic [data_w-1:0] res,
                                                   input logic cy);
    logic [data_w-1:0] f;
    f          = '0;
    f[flag_s]  = res[data_w-1];
    f[flag_z]  = (res == '0);
    f[flag_p]  = ~^res; // even parity.
    f[flag_cy] = cy;
    return f;
  endfunction

  assign op_b = read_data_1[data_w-1:0];

  always_comb begin
    case (req.code)
      op_add:         arith = {1'b0, accumulator} + {1'b0, op_b};
      op_sub, op_cmp: arith = {1'b0, accumulator} - {1'b0, op_b};
      op_ana:         arith = {1'b0, accumulator & op_b};
      op_xra:         arith = {1'b0, accumulator ^ op_b};
      op_ora:         arith = {1'b0, accumulator | op_b};
      default:        arith = '0;
    endcase
  end

  assign new_flags = calc_flags(arith[data_w-1:0], arith[data_w]);

  always_comb begin
    wb       = '0;
    wb.addr  = req.dst;
    wb.flags = flags;
    if (req.valid) begin
      case (req.code)
        op_mov: begin
          wb.write_en = 1'b1;
          wb.data     = pair_w'(op_b);
        end
        op_mvi: begin
          wb.write_en = 1'b1;
          wb.data     = pair_w'(req.imm[data_w-1:0]);
        end
        op_inr, op_dcr: begin
          wb.write_en = 1'b1;
          wb.data     = (req.code == op_inr) ? pair_w'(op_b + data_w'(1))
                                             : pair_w'(op_b - data_w'(1));
        end
        op_lxi, op_inx, op_dcx: begin
          wb.write_en = 1'b1;
          wb.rp_en    = 1'b1;
          case (req.code)
            op_inx:  wb.data = read_data_1 + pair_w'(1);
            op_dcx:  wb.data = read_data_1 - pair_w'(1);
            default: wb.data = req.imm;
          endcase
        end
        op_add, op_sub, op_ana, op_xra, op_ora: begin
          wb.write_en = 1'b1;
          wb.rp_en    = 1'b1;
          wb.addr     = {1'b0, pair_af}; // a and flags in one write.
          wb.data     = {arith[data_w-1:0], new_flags};
        end
        op_cmp: begin
          wb.flag_write_en = 1'b1;
          wb.flags         = new_flags;
        end
        default: begin
          wb.write_en = 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== hw/op_decoder.sv ====
`timescale 1ns/1ps

module op_decoder import isa_pkg::*, core_pkg::*; (
  input  logic      clk,
  input  logic      n_rst,
  input  logic      op_valid,
  input  core_op_t  op,
  output reg_addr_t read_addr_1,
  output logic      rp_en,
  output alu_req_t  req
);

  core_op_t          op_q;
  logic              valid_q;
  reg_addr_t         src;
  logic [pair_w-1:0] imm;

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      op_q <= op;
    end
  end

  assign src = op_q.operand.src_view.src;

  always_comb begin
    read_addr_1 = op_q.dst; // inr/dcr/inx/dcx read their own target.
    rp_en       = 1'b0;
    imm         = '0;
    case (op_q.code)
      op_mov, op_add, op_sub, op_ana, op_xra, op_ora, op_cmp: begin
        read_addr_1 = src;
      end
      op_mvi: begin
        imm = op_q.operand.imm_view;
      end
      op_lxi: begin
        rp_en = 1'b1;
        imm   = op_q.operand.imm_view;
      end
      op_inx, op_dcx: begin
        rp_en = 1'b1;
      end
      default: begin
        rp_en = 1'b0;
      end
    endcase
  end

  always_comb begin
    req.valid = valid_q;
    req.code  = op_q.code;
    req.dst   = op_q.dst;
    req.imm   = imm;
  end

endmodule

// ==== hw/reg_core.sv ====
`timescale 1ns/1ps

module reg_core import isa_pkg::*, core_pkg::*; (
  input  logic              clk,
  input  logic              n_rst,
  input  logic              op_valid,
  input  core_op_t          op,
  input  logic              insp_rp,
  input  reg_addr_t         insp_addr,
  output logic [pair_w-1:0] insp_data,
  output logic [data_w-1:0] accumulator,
  output logic [data_w-1:0] flags
);

  reg_addr_t         read_addr_1;
  logic              rd_rp_en;
  alu_req_t          req;
  logic [pair_w-1:0] read_data_1;
  wb_t               wb;

  op_decoder decoder_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .op_valid    (op_valid),
    .op          (op),
    .read_addr_1 (read_addr_1),
    .rp_en       (rd_rp_en),
    .req         (req)
  );

  reg_file reg_file_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .wb          (wb),
    .rp_en       (rd_rp_en),
    .read_addr_1 (read_addr_1),
    .insp_rp     (insp_rp),
    .insp_addr   (insp_addr),
    .read_data_1 (read_data_1),
    .insp_data   (insp_data),
    .accumulator (accumulator),
    .flags       (flags)
  );

  alu8 alu_i (
    .req         (req),
    .read_data_1 (read_data_1),
    .accumulator (accumulator),
    .flags       (flags),
    .wb          (wb)
  );

endmodule

// ==== regfile/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*, core_pkg::*; (
  input  logic              clk,
  input  logic              n_rst,
  input  wb_t               wb,
  input  logic              rp_en,
  input  reg_addr_t         read_addr_1,
  input  logic              insp_rp,
  input  reg_addr_t         insp_addr,
  output logic [pair_w-1:0] read_data_1,
  output logic [pair_w-1:0] insp_data,
  output logic [data_w-1:0] accumulator,
  output logic [data_w-1:0] flags
);

  logic [data_w-1:0] regs [8]; // indexed by byte address.

  function automatic reg_addr_t pair_hi(input logic [1:0] p);
    reg_addr_t r;
    case (p)
      pair_bc: r = reg_b;
      pair_de: r = reg_d;
      pair_hl: r = reg_h;
      default: r = reg_a;
    endcase
    return r;
  endfunction

  function automatic reg_addr_t pair_lo(input logic [1:0] p);
    reg_addr_t r;
    case (p)
      pair_bc: r = reg_c;
      pair_de: r = reg_e;
      pair_hl: r = reg_l;
      default: r = reg_flags; // a with flags.
    endcase
    return r;
  endfunction

  // byte reads zero-extend, pair reads put the high register first.
  function automatic logic [pair_w-1:0] read_port(input reg_addr_t addr, input logic rp);
    logic [pair_w-1:0] d;
    if (rp) begin
      d = {regs[pair_hi(addr[1:0])], regs[pair_lo(addr[1:0])]};
    end else begin
      d = pair_w'(regs[addr]);
    end
    return d;
  endfunction

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      regs <= '{default: '0};
    end else if (wb.write_en) begin
      if (wb.rp_en) begin
        regs[pair_hi(wb.addr[1:0])] <= wb.data[pair_w-1:data_w];
        regs[pair_lo(wb.addr[1:0])] <= wb.data[data_w-1:0];
      end else begin
        regs[wb.addr] <= wb.data[data_w-1:0];
      end
    end else if (wb.flag_write_en) begin
      regs[reg_flags] <= wb.flags; // cmp only.
    end
  end

  always_comb begin
    read_data_1 = read_port(read_addr_1, rp_en);
    insp_data   = read_port(insp_addr, insp_rp); // independent of the executing op.
  end

  assign accumulator = regs[reg_a];
  assign flags       = regs[reg_flags];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"
verilator --binary --assert --top-module reg_core_tb -f files.f -o reg_core_sim
./obj_dir/reg_core_sim | tee sim.log
if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
